// ==== verilog/game_pkg.sv ====
`default_nettype none

package game_pkg;

  // one-hot, bit 0 is the first switch / LED
  typedef logic [3:0] colour_t;

  typedef logic [2:0] round_t;
  typedef logic [4:0] score_t;
  typedef logic [1:0] lives_t;

  localparam int MAX_ROUNDS  = 6;
  localparam int START_LIVES = 3;

  // fixed pattern, round r plays the first r entries
  localparam colour_t PATTERN [MAX_ROUNDS] = '{
    4'b0001,
    4'b0010,
    4'b1000,
    4'b1000,
    4'b0100,
    4'b0001
  };

  // top level game states
  typedef enum logic [2:0] {
    st_idle,
    st_show,      // pattern playing
    st_entry,     // player entering
    st_life_lost,
    st_won,
    st_lost
  } game_state_t;

endpackage

`default_nettype wire

// ==== verilog/display_pkg.sv ====
`default_nettype none

package display_pkg;

  // active low, bit 0 is segment a
  typedef logic [6:0] seg_t;

  localparam seg_t SEG_DIGITS [10] = '{
    7'b1000000,
    7'b1111001,
    7'b0100100,
    7'b0110000,
    7'b0011001,
    7'b0010010,
    7'b0000010,
    7'b1111000,
    7'b0000000,
    7'b0011000
  };

  localparam seg_t SEG_L    = 7'b1000111;
  localparam seg_t SEG_DASH = 7'b0111111; // middle bar only

endpackage

`default_nettype wire

// ==== verilog/sequence_show.sv ====
`timescale 1ns/1ns
`default_nettype none

module sequence_show #(
  parameter int STEP_CYCLES = 25_000_000
) (
  input  logic              CLOCK_50,
  input  logic              resetn,
  input  logic              show_req,
  input  game_pkg::round_t  round_len,
  output logic              show_ack,
  output game_pkg::colour_t show_led
);

  import game_pkg::*;

  // one step is a dark phase then a lit phase
  localparam int PHASE_W = $clog2(2 * STEP_CYCLES);
  localparam logic [PHASE_W-1:0] PHASE_LAST = PHASE_W'(2 * STEP_CYCLES - 1);
  localparam logic [PHASE_W-1:0] LIT_START  = PHASE_W'(STEP_CYCLES);

  typedef enum logic [1:0] {
    sh_idle,
    sh_play,
    sh_ack
  } show_state_t;

  show_state_t state;
  logic [PHASE_W-1:0] phase_cnt;
  round_t step;

  assign show_led = (state == sh_play && phase_cnt >= LIT_START) ? PATTERN[step] : '0;

  always_ff @(posedge CLOCK_50)
  begin
    if (!resetn)
    begin
      state <= sh_idle;
      phase_cnt <= '0;
      step <= '0;
      show_ack <= 1'b0;
    end
    else
    begin
      case (state)
        sh_idle:
          if (show_req)
          begin
            phase_cnt <= '0;
            step <= '0;
            state <= sh_play;
          end
        sh_play:
          if (phase_cnt != PHASE_LAST)
            phase_cnt <= phase_cnt + 1'b1;
          else
          begin
            phase_cnt <= '0;
            if (step == round_len - 3'd1)
            begin
              show_ack <= 1'b1;
              state <= sh_ack;
            end
            else
              step <= step + 1'b1;
          end
        sh_ack:
          if (!show_req) // controller saw the ack
          begin
            show_ack <= 1'b0;
            state <= sh_idle;
          end
        default: state <= sh_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/entry_judge.sv ====
`timescale 1ns/1ns
`default_nettype none

module entry_judge #(
  parameter int ENTRY_CYCLES = 50_000_000
) (
  input  logic              CLOCK_50,
  input  logic              resetn,
  input  logic              judge_req,
  input  game_pkg::round_t  round_len,
  input  game_pkg::colour_t colour,
  output logic              judge_ack,
  output logic              judge_pass,
  output logic              first_entry
);

  import game_pkg::*;

  localparam int WIN_W = $clog2(ENTRY_CYCLES);
  localparam logic [WIN_W-1:0] WIN_LAST = WIN_W'(ENTRY_CYCLES - 1);

  typedef enum logic [1:0] {
    jd_idle,
    jd_run,
    jd_done
  } judge_state_t;

  judge_state_t state;
  logic [WIN_W-1:0] win_cnt;
  round_t step;
  logic hit;
  logic win_end;

  assign hit = (colour == PATTERN[step]);
  assign win_end = (state == jd_run) && (win_cnt == WIN_LAST);
  assign first_entry = (state == jd_run) && (step == '0);

  always_ff @(posedge CLOCK_50)
  begin
    if (!resetn)
    begin
      state <= jd_idle;
      win_cnt <= '0;
      step <= '0;
      judge_ack <= 1'b0;
    end
    else
    begin
      case (state)
        jd_idle:
          if (judge_req)
          begin
            win_cnt <= '0;
            step <= '0;
            state <= jd_run;
          end
        jd_run:
          if (!win_end)
            win_cnt <= win_cnt + 1'b1;
          else if (!hit || step == round_len - 3'd1)
          begin
            // first miss or last good entry ends the round
            judge_ack <= 1'b1;
            state <= jd_done;
          end
          else
          begin
            win_cnt <= '0;
            step <= step + 1'b1;
          end
        jd_done:
          if (!judge_req)
          begin
            judge_ack <= 1'b0;
            state <= jd_idle;
          end
        default: state <= jd_idle;
      endcase
    end
  end

  // result of the latest sample, held through jd_done
  always_ff @(posedge CLOCK_50)
  begin
    if (win_end)
      judge_pass <= hit;
  end

endmodule

`default_nettype wire

// ==== verilog/game_control.sv ====
`timescale 1ns/1ns
`default_nettype none

module game_control (
  input  logic             CLOCK_50,
  input  logic             resetn,
  input  logic             go,
  input  logic             show_ack,
  input  logic             judge_ack,
  input  logic             judge_pass,
  output logic             show_req,
  output logic             judge_req,
  output game_pkg::round_t round_len,
  output logic [1:0]       turn_led,
  output logic             win_led,
  output game_pkg::score_t score,
  output game_pkg::score_t high_score,
  output game_pkg::lives_t lives
);

  import game_pkg::*;

  game_state_t state;
  score_t score_sum;

  // score once the current round is cleared
  assign score_sum = score + score_t'(round_len);
  assign win_led = (state == st_won);

  always_comb
  begin
    case (state)
      st_show:  turn_led = 2'b01;
      st_entry: turn_led = 2'b10;
      default:  turn_led = 2'b00;
    endcase
  end

  always_ff @(posedge CLOCK_50)
  begin
    if (!resetn)
    begin
      state <= st_idle;
      show_req <= 1'b0;
      judge_req <= 1'b0;
      round_len <= '0;
      score <= '0;
      high_score <= '0;
      lives <= lives_t'(START_LIVES);
    end
    else
    begin
      case (state)
        st_idle, st_won, st_lost:
          if (go)
          begin
            round_len <= round_t'(1);
            lives <= lives_t'(START_LIVES);
            score <= '0;
            show_req <= 1'b1;
            state <= st_show;
          end
        st_show:
          if (show_ack)
          begin
            show_req <= 1'b0;
            judge_req <= 1'b1;
            state <= st_entry;
          end
        st_entry:
          if (judge_ack)
          begin
            judge_req <= 1'b0;
            if (!judge_pass)
              state <= st_life_lost;
            else if (round_len == round_t'(MAX_ROUNDS))
            begin
              score <= score_sum;
              if (score_sum > high_score)
                high_score <= score_sum;
              state <= st_won;
            end
            else
            begin
              score <= score_sum;
              round_len <= round_len + 1'b1;
              show_req <= 1'b1;
              state <= st_show;
            end
          end
        st_life_lost:
          if (lives == lives_t'(1)) // last life gone
          begin
            lives <= '0;
            if (score > high_score)
              high_score <= score;
            state <= st_lost;
          end
          else
          begin
            lives <= lives - 1'b1;
            show_req <= 1'b1; // replay same round
            state <= st_show;
          end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/score_display.sv ====
`timescale 1ns/1ns
`default_nettype none

module score_display (
  input  game_pkg::score_t  score,
  input  game_pkg::score_t  high_score,
  input  game_pkg::lives_t  lives,
  output display_pkg::seg_t hex0,
  output display_pkg::seg_t hex1,
  output display_pkg::seg_t hex4,
  output display_pkg::seg_t hex6,
  output display_pkg::seg_t hex7
);

  import display_pkg::*;

  logic [3:0] score_ones;
  logic [3:0] score_tens;
  logic [3:0] high_ones;
  logic [3:0] high_tens;

  function automatic seg_t digit_seg(input logic [3:0] d);
    if (d > 4'd9)
      return SEG_DASH;
    return SEG_DIGITS[d];
  endfunction

  // values stay below 32, tens is 0 to 3
  assign score_ones = 4'(score % 5'd10);
  assign score_tens = 4'(score / 5'd10);
  assign high_ones = 4'(high_score % 5'd10);
  assign high_tens = 4'(high_score / 5'd10);

  assign hex0 = digit_seg(score_ones);
  assign hex1 = digit_seg(score_tens);
  assign hex6 = digit_seg(high_ones);
  assign hex7 = digit_seg(high_tens);

  // no lives left only after a lost game
  assign hex4 = (lives == '0) ? SEG_L : digit_seg({2'b00, lives});

endmodule

`default_nettype wire

// ==== verilog/simon_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module simon_top #(
  parameter int STEP_CYCLES  = 25_000_000,
  parameter int ENTRY_CYCLES = 50_000_000
) (
  input  logic              CLOCK_50,
  input  logic              resetn,
  input  logic              go,
  input  game_pkg::colour_t colour,
  output game_pkg::colour_t pattern_led,
  output logic [1:0]        turn_led,
  output logic              first_entry_led,
  output display_pkg::seg_t hex0,
  output display_pkg::seg_t hex1,
  output display_pkg::seg_t hex4,
  output display_pkg::seg_t hex6,
  output display_pkg::seg_t hex7
);

  import game_pkg::*;

  logic show_req;
  logic show_ack;
  logic judge_req;
  logic judge_ack;
  logic judge_pass;
  logic win_led;
  round_t round_len;
  colour_t show_led;
  score_t score;
  score_t high_score;
  lives_t lives;

  // all four lit after a win
  assign pattern_led = show_led | {4{win_led}};

  sequence_show #(
    .STEP_CYCLES (STEP_CYCLES)
  ) u_show (
    .CLOCK_50  (CLOCK_50),
    .resetn    (resetn),
    .show_req  (show_req),
    .round_len (round_len),
    .show_ack  (show_ack),
    .show_led  (show_led)
  );

  entry_judge #(
    .ENTRY_CYCLES (ENTRY_CYCLES)
  ) u_judge (
    .CLOCK_50    (CLOCK_50),
    .resetn      (resetn),
    .judge_req   (judge_req),
    .round_len   (round_len),
    .colour      (colour),
    .judge_ack   (judge_ack),
    .judge_pass  (judge_pass),
    .first_entry (first_entry_led)
  );

  game_control u_control (
    .CLOCK_50   (CLOCK_50),
    .resetn     (resetn),
    .go         (go),
    .show_ack   (show_ack),
    .judge_ack  (judge_ack),
    .judge_pass (judge_pass),
    .show_req   (show_req),
    .judge_req  (judge_req),
    .round_len  (round_len),
    .turn_led   (turn_led),
    .win_led    (win_led),
    .score      (score),
    .high_score (high_score),
    .lives      (lives)
  );

  score_display u_display (
    .score      (score),
    .high_score (high_score),
    .lives      (lives),
    .hex0       (hex0),
    .hex1       (hex1),
    .hex4       (hex4),
    .hex6       (hex6),
    .hex7       (hex7)
  );

endmodule

`default_nettype wire

// ==== testbench/simon_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module simon_tb;

  localparam int STEP_CYCLES  = 4;
  localparam int ENTRY_CYCLES = 16;
  localparam int MAX_GAMES    = 16;

  logic       CLOCK_50;
  logic       resetn;
  logic       go;
  logic [3:0] colour;
  logic [3:0] pattern_led;
  logic [1:0] turn_led;
  logic       first_entry_led;
  logic [6:0] hex0;
  logic [6:0] hex1;
  logic [6:0] hex4;
  logic [6:0] hex6;
  logic [6:0] hex7;

  int miss_round [MAX_GAMES];
  int miss_step  [MAX_GAMES];
  int miss_count [MAX_GAMES];
  int end_score  [MAX_GAMES];
  int end_lives  [MAX_GAMES];
  int end_high   [MAX_GAMES];
  int game_count;
  int errors;
  int tests_failed;
  int high_model;
  int cycle_count = 0;
  int cycle_limit = 1000;
  logic [31:0] rand_state;

  simon_top #(
    .STEP_CYCLES  (STEP_CYCLES),
    .ENTRY_CYCLES (ENTRY_CYCLES)
  ) u_simon_top (
    .CLOCK_50        (CLOCK_50),
    .resetn          (resetn),
    .go              (go),
    .colour          (colour),
    .pattern_led     (pattern_led),
    .turn_led        (turn_led),
    .first_entry_led (first_entry_led),
    .hex0            (hex0),
    .hex1            (hex1),
    .hex4            (hex4),
    .hex6            (hex6),
    .hex7            (hex7)
  );

  initial
  begin
    CLOCK_50 = 1'b0;
    forever #2 CLOCK_50 = ~CLOCK_50;
  end

  always @(posedge CLOCK_50)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > cycle_limit)
    begin
      $display("timeout, the run was still going after %0d cycles", cycle_count);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  function automatic logic [3:0] pattern_at(input int idx);
    case (idx)
      0: return 4'b0001;
      1: return 4'b0010;
      2: return 4'b1000;
      3: return 4'b1000;
      4: return 4'b0100;
      default: return 4'b0001;
    endcase
  endfunction

  // active low, bit 0 is segment a, 10 means L
  function automatic logic [6:0] seg_code(input int value);
    case (value)
      0: return 7'b1000000;
      1: return 7'b1111001;
      2: return 7'b0100100;
      3: return 7'b0110000;
      4: return 7'b0011001;
      5: return 7'b0010010;
      6: return 7'b0000010;
      7: return 7'b1111000;
      8: return 7'b0000000;
      9: return 7'b0011000;
      default: return 7'b1000111;
    endcase
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("error at %0t ns: %s", $time, msg);
  endtask

  task automatic report_test(input string name, input int err_before);
    if (errors == err_before)
      $display("test %s: ok", name);
    else
    begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - err_before);
    end
  endtask

  task automatic check_display(input int score, input int lives, input int high,
                               input string where);
    if (hex0 !== seg_code(score % 10) || hex1 !== seg_code(score / 10))
      report_error($sformatf("%s: score shows %b %b, expected %0d", where, hex1, hex0, score));
    if (hex4 !== seg_code(lives == 0 ? 10 : lives))
      report_error($sformatf("%s: lives shows %b, expected %0d", where, hex4, lives));
    if (hex6 !== seg_code(high % 10) || hex7 !== seg_code(high / 10))
      report_error($sformatf("%s: high score shows %b %b, expected %0d", where, hex7, hex6,
                             high));
  endtask

  // one of the three one-hot values that differ from right
  task automatic pick_wrong_colour(input logic [3:0] right, output logic [3:0] wrong);
    int pick;
    int seen;
    rand_state = lcg_next(rand_state);
    pick = int'(rand_state[23:16]) % 3;
    seen = 0;
    wrong = 4'b0000;
    for (int b = 0; b < 4; b++)
    begin
      if (right[b] == 1'b0)
      begin
        if (seen == pick)
          wrong = 4'b0001 << b;
        seen++;
      end
    end
  endtask

  task automatic load_stimulus();
    int fd;
    int n;
    int f_round;
    int f_step;
    int f_count;
    int f_score;
    int f_lives;
    int f_high;
    logic [8*128-1:0] line_buf;
    game_count = 0;
    cycle_limit = 100; // reset and start up
    fd = $fopen("testbench/simon_stimulus.txt", "r");
    if (fd == 0)
      $display("could not open testbench/simon_stimulus.txt");
    else
    begin
      while (!$feof(fd) && game_count < MAX_GAMES)
      begin
        line_buf = '0;
        n = $fgets(line_buf, fd);
        if (n > 0 && $sscanf(line_buf, "%d %d %d %d %d %d", f_round, f_step, f_count,
                             f_score, f_lives, f_high) == 6)
        begin
          miss_round[game_count] = f_round;
          miss_step[game_count] = f_step;
          miss_count[game_count] = f_count;
          end_score[game_count] = f_score;
          end_lives[game_count] = f_lives;
          end_high[game_count] = f_high;
          // every try as long as a full round 6
          cycle_limit += (6 + f_count) * (12 * STEP_CYCLES + 6 * ENTRY_CYCLES + 20) + 20;
          game_count++;
        end
      end
      $fclose(fd);
    end
    cycle_limit = 2 * cycle_limit;
  endtask

  task automatic wait_turn(input logic [1:0] value);
    while (turn_led !== value)
      @(negedge CLOCK_50);
  endtask

  // collects lit phases until the player's turn
  task automatic watch_show(input int round);
    int lit_count;
    logic [3:0] last_led;
    lit_count = 0;
    last_led = 4'b0000;
    while (turn_led === 2'b01)
    begin
      if (pattern_led !== 4'b0000 && last_led === 4'b0000)
      begin
        if (lit_count >= round || pattern_led !== pattern_at(lit_count))
          report_error($sformatf("round %0d lit phase %0d shows %b", round, lit_count,
                                 pattern_led));
        lit_count++;
      end
      last_led = pattern_led;
      @(negedge CLOCK_50);
    end
    if (lit_count != round)
      report_error($sformatf("round %0d showed %0d colours", round, lit_count));
  endtask

  // entry k goes in at the middle of window k
  task automatic enter_round(input int round, input int bad_step);
    int elapsed;
    logic [3:0] wrong;
    elapsed = 0;
    for (int k = 0; k < round; k++)
    begin
      while (elapsed < ENTRY_CYCLES / 2 + k * ENTRY_CYCLES)
      begin
        @(negedge CLOCK_50);
        elapsed++;
      end
      if (first_entry_led !== (k == 0))
        report_error($sformatf("first entry LED is %b in window %0d", first_entry_led, k));
      if (k == bad_step)
      begin
        pick_wrong_colour(pattern_at(k), wrong);
        colour = wrong;
        break;
      end
      colour = pattern_at(k);
    end
    while (turn_led === 2'b10)
      @(negedge CLOCK_50);
    colour = 4'b0000;
  endtask

  task automatic play_game(input int g);
    int round;
    int lives;
    int score;
    int fails;
    int bad_step;
    bit over;
    round = 1;
    lives = 3;
    score = 0;
    fails = 0;
    over = 1'b0;
    @(negedge CLOCK_50);
    go = 1'b1;
    @(negedge CLOCK_50);
    go = 1'b0;
    while (!over)
    begin
      wait_turn(2'b01);
      watch_show(round);
      if (turn_led !== 2'b10)
        report_error($sformatf("turn LEDs %b after round %0d was shown", turn_led, round));
      check_display(score, lives, high_model, $sformatf("game %0d round %0d", g + 1, round));
      bad_step = -1;
      if (round == miss_round[g] && fails < miss_count[g])
        bad_step = miss_step[g];
      enter_round(round, bad_step);
      if (bad_step >= 0)
      begin
        fails++;
        lives--;
        if (lives == 0)
          over = 1'b1;
      end
      else
      begin
        score += round;
        if (round == 6)
          over = 1'b1;
        else
          round++;
      end
    end
    repeat (3) @(negedge CLOCK_50); // controller overhead
    if (score > high_model)
      high_model = score;
    if (turn_led !== 2'b00)
      report_error($sformatf("turn LEDs %b after the game ended", turn_led));
    if (pattern_led !== (lives == 0 ? 4'b0000 : 4'b1111))
      report_error($sformatf("pattern LEDs %b after the game ended", pattern_led));
    check_display(end_score[g], end_lives[g], end_high[g], $sformatf("game %0d end", g + 1));
    if (score != end_score[g] || lives != end_lives[g] || high_model != end_high[g])
    begin
      errors++;
      $display("stimulus line for game %0d does not agree with the game rules", g + 1);
    end
  endtask

  initial
  begin
    int err_before;
    resetn = 1'b0;
    go = 1'b0;
    colour = 4'b0000;
    errors = 0;
    tests_failed = 0;
    high_model = 0;
    rand_state = 32'h9847;
    load_stimulus();
    repeat (5) @(negedge CLOCK_50);
    resetn = 1'b1;
    @(negedge CLOCK_50);
    err_before = errors;
    if (turn_led !== 2'b00 || pattern_led !== 4'b0000)
      report_error($sformatf("after reset turn %b pattern %b", turn_led, pattern_led));
    check_display(0, 3, 0, "after reset");
    report_test("reset", err_before);
    if (game_count == 0)
    begin
      errors++;
      $display("no games were read from the stimulus file");
    end
    for (int g = 0; g < game_count; g++)
    begin
      err_before = errors;
      play_game(g);
      report_test($sformatf("game %0d", g + 1), err_before);
    end
    $display("%0d tests, %0d failed, %0d errors", game_count + 1, tests_failed, errors);
    if (errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/simon_stimulus.txt ====
# miss_round miss_step miss_count end_score end_lives end_high
# miss_round 0 is a clean game, miss_count wrong tries in that round
2 0 3 1 0 1
5 3 3 10 0 10
3 2 3 3 0 10
3 1 1 21 2 21
0 0 0 21 3 21
6 5 2 21 1 21
1 0 3 0 0 21

// ==== project.f ====
verilog/game_pkg.sv
verilog/display_pkg.sv
verilog/sequence_show.sv
verilog/entry_judge.sv
verilog/game_control.sv
verilog/score_display.sv
verilog/simon_top.sv
testbench/simon_tb.sv

// ==== Bender.yml ====
package:
  name: simon

sources:
  - verilog/game_pkg.sv
  - verilog/display_pkg.sv
  - verilog/sequence_show.sv
  - verilog/entry_judge.sv
  - verilog/game_control.sv
  - verilog/score_display.sv
  - verilog/simon_top.sv
  - target: simulation
    files:
      - testbench/simon_tb.sv
